// File: ex_stimulus.txt
# name aluop sel reg1 reg2 wd wreg  exp_wd exp_wreg exp_wdata  exp_hi exp_lo
# all hex; exp_hi/exp_lo are HI and LO three edges after issue
or_basic      25 1 f0f00000 00000f0f 01 1  01 1 f0f00f0f  00000000 00000000
and_basic     24 1 ff00ff00 0ff00ff0 02 1  02 1 0f000f00  00000000 00000000
xor_basic     26 1 aaaa5555 ffff0000 03 1  03 1 55555555  00000000 00000000
nor_basic     27 1 12345678 0000ffff 04 1  04 1 edcb0000  00000000 00000000
or_no_wreg    25 1 00000001 00000002 05 0  05 0 00000003  00000000 00000000
sll_4         7c 2 00000004 00000001 06 1  06 1 00000010  00000000 00000000
sll_low_bits  7c 2 ffffffe3 0000000f 06 1  06 1 00000078  00000000 00000000
srl_8         02 2 00000008 80000000 07 1  07 1 00800000  00000000 00000000
sra_neg_0     03 2 00000000 80000001 08 1  08 1 80000001  00000000 00000000
sra_neg_31    03 2 0000001f 80000000 09 1  09 1 ffffffff  00000000 00000000
sra_neg_4     03 2 00000004 f0000010 0a 1  0a 1 ff000001  00000000 00000000
sra_pos_31    03 2 0000001f 7fffffff 0b 1  0b 1 00000000  00000000 00000000
# HI/LO through the architectural registers
mthi_arch     11 0 11111111 00000000 00 0  00 0 00000000  11111111 00000000
nop_a         00 0 00000000 00000000 00 0  00 0 00000000  11111111 00000000
nop_b         00 0 00000000 00000000 00 0  00 0 00000000  11111111 00000000
mfhi_arch     10 3 00000000 00000000 0c 1  0c 1 11111111  11111111 00000000
mtlo_arch     13 0 22222222 00000000 00 0  00 0 00000000  11111111 22222222
nop_c         00 0 00000000 00000000 00 0  00 0 00000000  11111111 22222222
nop_d         00 0 00000000 00000000 00 0  00 0 00000000  11111111 22222222
mflo_arch     12 3 00000000 00000000 0d 1  0d 1 22222222  11111111 22222222
# Memory and write-back taps
mthi_mem      11 0 33333333 00000000 00 0  00 0 00000000  33333333 22222222
mfhi_mem      10 3 00000000 00000000 0e 1  0e 1 33333333  33333333 22222222
mtlo_wb       13 0 44444444 00000000 00 0  00 0 00000000  33333333 44444444
xor_between   26 1 00000000 0000abcd 10 1  10 1 0000abcd  33333333 44444444
mflo_wb       12 3 00000000 00000000 0f 1  0f 1 44444444  33333333 44444444
mthi_pair     11 0 55555555 00000000 00 0  00 0 00000000  55555555 44444444
mtlo_pair     13 0 66666666 00000000 00 0  00 0 00000000  55555555 66666666
# Conditional moves and unknown selector
movz_write    0a 3 abcdef01 00000000 11 1  11 1 abcdef01  55555555 66666666
movn_no_write 0b 3 abcdef01 00000000 12 0  12 0 abcdef01  55555555 66666666
movn_write    0b 3 13579bdf 00000001 13 1  13 1 13579bdf  55555555 66666666
bad_sel       25 7 ffffffff ffffffff 14 1  14 1 00000000  55555555 66666666
nop_end       00 0 00000000 00000000 00 0  00 0 00000000  55555555 66666666

// File: files.f
openmips_pkg.sv
ex.sv
result_pipe.sv
hilo_reg.sv
ex_back_top.sv
tb_ex_back.sv

// File: Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module tb_ex_back -f files.f \
		--Mdir obj_dir -o sim_ex_back

run: compile
	./obj_dir/sim_ex_back | tee sim.log
	@if grep -q "Test failed" sim.log; then exit 1; fi
	@grep -q "Test passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: tb_ex_back.sv
`timescale 1ns/1ps

module tb_ex_back;

    logic                  clk;
    logic                  rst_i;
    openmips_pkg::ex_op_t  op_i;
    openmips_pkg::wb_req_t wb_o;
    openmips_pkg::reg_t    hi_o;
    openmips_pkg::reg_t    lo_o;

    int          wb_errs = 0;
    int          word_errs = 0;
    int          other_errs = 0;
    int          cyc = 0;
    logic        loaded = 1'b0;
    logic [31:0] seed = 32'd82605;

    // Directed vectors from the stimulus file
    string                 vec_name_q[$];
    openmips_pkg::ex_op_t  vec_op_q[$];
    openmips_pkg::wb_req_t vec_wb_q[$];
    openmips_pkg::reg_t    vec_hi_q[$];
    openmips_pkg::reg_t    vec_lo_q[$];

    // Expectations waiting for their cycle
    int                    wb_due_q[$];
    string                 wb_name_q[$];
    openmips_pkg::wb_req_t wb_exp_q[$];
    int                    hilo_due_q[$];
    string                 hilo_name_q[$];
    openmips_pkg::reg_t    hi_exp_q[$];
    openmips_pkg::reg_t    lo_exp_q[$];

    ex_back_top DUT (
        .clk   (clk),
        .rst_i (rst_i),
        .op_i  (op_i),
        .wb_o  (wb_o),
        .hi_o  (hi_o),
        .lo_o  (lo_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Reference for logic and shift ops
    function automatic openmips_pkg::reg_t expect_result(input openmips_pkg::aluop_t op,
            input openmips_pkg::reg_t a, input openmips_pkg::reg_t b);
        logic [4:0]         sh;
        openmips_pkg::reg_t sign_fill;
        sh = a[4:0];
        sign_fill = b[31] ? ~(32'hffff_ffff >> sh) : 32'h0;
        case (op)
            openmips_pkg::EXE_OR_OP:  return a | b;
            openmips_pkg::EXE_AND_OP: return a & b;
            openmips_pkg::EXE_XOR_OP: return a ^ b;
            openmips_pkg::EXE_NOR_OP: return ~(a | b);
            openmips_pkg::EXE_SLL_OP: return b << sh;
            openmips_pkg::EXE_SRL_OP: return b >> sh;
            openmips_pkg::EXE_SRA_OP: return (b >> sh) | sign_fill;
            default:                  return openmips_pkg::ZERO_WORD;
        endcase
    endfunction

    task automatic check_wb(input string name, input openmips_pkg::wb_req_t exp,
                            input openmips_pkg::wb_req_t act);
        if (act !== exp) begin
            wb_errs++;
            $display("error %s: expected wd=%0d wreg=%0d wdata=%h, got wd=%0d wreg=%0d wdata=%h",
                     name, exp.wd, exp.wreg, exp.wdata, act.wd, act.wreg, act.wdata);
        end
    endtask

    task automatic check_word(input string name, input openmips_pkg::reg_t exp,
                              input openmips_pkg::reg_t act);
        if (act !== exp) begin
            word_errs++;
            $display("error %s: expected %h, got %h", name, exp, act);
        end
    endtask

    task automatic read_vectors();
        int                      fd;
        int                      cnt;
        string                   line;
        string                   name;
        openmips_pkg::aluop_t    aluop;
        openmips_pkg::alusel_t   sel;
        openmips_pkg::reg_t      r1, r2, xdata, xhi, xlo;
        openmips_pkg::reg_addr_t wd, xwd;
        logic                    wreg, xwreg;
        fd = $fopen("ex_stimulus.txt", "r");
        if (fd == 0) begin
            other_errs++;
            $display("cannot open ex_stimulus.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                cnt = $fgets(line, fd);
                if (line.len() > 1 && line.getc(0) != "#") begin
                    cnt = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h", name, aluop,
                                  sel, r1, r2, wd, wreg, xwd, xwreg, xdata, xhi, xlo);
                    if (cnt == 12) begin
                        vec_name_q.push_back(name);
                        vec_op_q.push_back('{aluop, sel, r1, r2, wd, wreg});
                        vec_wb_q.push_back('{xwd, xwreg, xdata});
                        vec_hi_q.push_back(xhi);
                        vec_lo_q.push_back(xlo);
                    end else begin
                        other_errs++;
                        $display("malformed stimulus line: %s", line);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // wb_o is due two edges after issue, HI/LO three
    task automatic issue_op(input string name, input openmips_pkg::ex_op_t op,
                            input openmips_pkg::wb_req_t exp_wb,
                            input openmips_pkg::reg_t exp_hi, input openmips_pkg::reg_t exp_lo);
        @(posedge clk);
        op_i <= op;
        wb_due_q.push_back(cyc + 3);
        wb_name_q.push_back(name);
        wb_exp_q.push_back(exp_wb);
        hilo_due_q.push_back(cyc + 4);
        hilo_name_q.push_back(name);
        hi_exp_q.push_back(exp_hi);
        lo_exp_q.push_back(exp_lo);
    endtask

    task automatic run_random(input openmips_pkg::reg_t hi, input openmips_pkg::reg_t lo);
        openmips_pkg::aluop_t ops [7] = '{openmips_pkg::EXE_OR_OP, openmips_pkg::EXE_AND_OP,
                                          openmips_pkg::EXE_XOR_OP, openmips_pkg::EXE_NOR_OP,
                                          openmips_pkg::EXE_SLL_OP, openmips_pkg::EXE_SRL_OP,
                                          openmips_pkg::EXE_SRA_OP};
        openmips_pkg::ex_op_t op;
        int                   pick;
        for (int i = 0; i < 200; i++) begin
            seed = lcg_next(seed);
            op.reg1 = seed;
            seed = lcg_next(seed);
            op.reg2 = seed;
            seed = lcg_next(seed);
            pick = int'(seed[31:16]) % 7;
            op.aluop = ops[pick];
            op.alusel = (pick < 4) ? openmips_pkg::EXE_RES_LOGIC : openmips_pkg::EXE_RES_SHIFT;
            op.wd = seed[20:16];
            op.wreg = seed[9];
            issue_op($sformatf("random_%0d", i), op,
                     '{op.wd, op.wreg, expect_result(op.aluop, op.reg1, op.reg2)}, hi, lo);
        end
    endtask

    always @(negedge clk) begin
        if (wb_due_q.size() > 0 && wb_due_q[0] == cyc) begin
            check_wb(wb_name_q[0], wb_exp_q[0], wb_o);
            wb_due_q.delete(0);
            wb_name_q.delete(0);
            wb_exp_q.delete(0);
        end
        if (hilo_due_q.size() > 0 && hilo_due_q[0] == cyc) begin
            check_word({hilo_name_q[0], " hi"}, hi_exp_q[0], hi_o);
            check_word({hilo_name_q[0], " lo"}, lo_exp_q[0], lo_o);
            hilo_due_q.delete(0);
            hilo_name_q.delete(0);
            hi_exp_q.delete(0);
            lo_exp_q.delete(0);
        end
    end

    initial begin
        openmips_pkg::reg_t last_hi;
        openmips_pkg::reg_t last_lo;
        rst_i <= 1'b1;
        op_i  <= '0;
        last_hi = openmips_pkg::ZERO_WORD;
        last_lo = openmips_pkg::ZERO_WORD;
        read_vectors();
        loaded = 1'b1;
        repeat (10) @(posedge clk);
        rst_i <= 1'b0;
        @(negedge clk);
        // Reset clears every field of the write-back request
        check_wb("reset wb", '0, wb_o);
        check_word("reset hi", openmips_pkg::ZERO_WORD, hi_o);
        check_word("reset lo", openmips_pkg::ZERO_WORD, lo_o);
        for (int i = 0; i < vec_name_q.size(); i++) begin
            issue_op(vec_name_q[i], vec_op_q[i], vec_wb_q[i], vec_hi_q[i], vec_lo_q[i]);
            last_hi = vec_hi_q[i];
            last_lo = vec_lo_q[i];
        end
        run_random(last_hi, last_lo);
        @(posedge clk);
        op_i <= '0;
        while (hilo_due_q.size() > 0) @(posedge clk);
        $display("errors: wb %0d, word %0d, other %0d", wb_errs, word_errs, other_errs);
        if (wb_errs + word_errs + other_errs == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Limit scales with vector count
    initial begin
        wait (loaded);
        #((vec_name_q.size() + 200 + 20) * 4 * 2);
        $display("watchdog expired before all results were checked");
        $display("Test failed");
        $finish;
    end

endmodule

// File: ex_back_top.sv
`timescale 1ns/1ps

module ex_back_top (
    input  logic                  clk,
    input  logic                  rst_i,
    input  openmips_pkg::ex_op_t  op_i,
    output openmips_pkg::wb_req_t wb_o,
    output openmips_pkg::reg_t    hi_o,
    output openmips_pkg::reg_t    lo_o
);

    openmips_pkg::wb_req_t   ex_wb;
    openmips_pkg::hilo_req_t ex_hilo;
    openmips_pkg::hilo_req_t mem_hilo;
    openmips_pkg::hilo_req_t wb_hilo;
    openmips_pkg::reg_t      hi;
    openmips_pkg::reg_t      lo;

    ex u_ex (
        .op_i       (op_i),
        .hi_i       (hi),
        .lo_i       (lo),
        .mem_hilo_i (mem_hilo),
        .wb_hilo_i  (wb_hilo),
        .wb_o       (ex_wb),
        .hilo_o     (ex_hilo)
    );

    result_pipe u_result_pipe (
        .clk        (clk),
        .rst_i      (rst_i),
        .ex_wb_i    (ex_wb),
        .ex_hilo_i  (ex_hilo),
        .mem_hilo_o (mem_hilo),
        .wb_hilo_o  (wb_hilo),
        .wb_o       (wb_o)
    );

    // Write-back HI/LO request doubles as the register write port
    hilo_reg u_hilo_reg (
        .clk       (clk),
        .rst_i     (rst_i),
        .we_hilo_i (wb_hilo),
        .hi_o      (hi),
        .lo_o      (lo)
    );

    assign hi_o = hi;
    assign lo_o = lo;

endmodule

// File: hilo_reg.sv
`timescale 1ns/1ps

module hilo_reg (
    input  logic                    clk,
    input  logic                    rst_i,
    input  openmips_pkg::hilo_req_t we_hilo_i,
    output openmips_pkg::reg_t      hi_o,
    output openmips_pkg::reg_t      lo_o
);

    openmips_pkg::reg_t hi_q;
    openmips_pkg::reg_t lo_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            hi_q <= openmips_pkg::ZERO_WORD;
            lo_q <= openmips_pkg::ZERO_WORD;
        end else if (we_hilo_i.whilo) begin
            hi_q <= we_hilo_i.hi;
            lo_q <= we_hilo_i.lo;
        end
    end

    assign hi_o = hi_q;
    assign lo_o = lo_q;

endmodule

// File: result_pipe.sv
`timescale 1ns/1ps

module result_pipe (
    input  logic                    clk,
    input  logic                    rst_i,
    input  openmips_pkg::wb_req_t   ex_wb_i,
    input  openmips_pkg::hilo_req_t ex_hilo_i,
    output openmips_pkg::hilo_req_t mem_hilo_o,
    output openmips_pkg::hilo_req_t wb_hilo_o,
    output openmips_pkg::wb_req_t   wb_o
);

    openmips_pkg::wb_req_t   mem_wb_q;
    openmips_pkg::hilo_req_t mem_hilo_q;
    openmips_pkg::wb_req_t   wb_wb_q;
    openmips_pkg::hilo_req_t wb_hilo_q;

    // EX/MEM
    always_ff @(posedge clk) begin
        if (rst_i) begin
            mem_wb_q   <= '0;
            mem_hilo_q <= '0;
        end else begin
            mem_wb_q   <= ex_wb_i;
            mem_hilo_q <= ex_hilo_i;
        end
    end

    // MEM/WB, memory stage does no work
    always_ff @(posedge clk) begin
        if (rst_i) begin
            wb_wb_q   <= '0;
            wb_hilo_q <= '0;
        end else begin
            wb_wb_q   <= mem_wb_q;
            wb_hilo_q <= mem_hilo_q;
        end
    end

    assign mem_hilo_o = mem_hilo_q;
    assign wb_hilo_o  = wb_hilo_q;
    assign wb_o       = wb_wb_q;

    // No stray writes right out of reset
    assert property (@(posedge clk) rst_i |=> !wb_o.wreg && !wb_hilo_o.whilo)
        else $error("result_pipe: write strobe set after reset");

endmodule

// File: ex.sv
`timescale 1ns/1ps

module ex (
    input  openmips_pkg::ex_op_t    op_i,
    input  openmips_pkg::reg_t      hi_i,
    input  openmips_pkg::reg_t      lo_i,
    input  openmips_pkg::hilo_req_t mem_hilo_i,
    input  openmips_pkg::hilo_req_t wb_hilo_i,
    output openmips_pkg::wb_req_t   wb_o,
    output openmips_pkg::hilo_req_t hilo_o
);

    openmips_pkg::reg_t logic_res;
    openmips_pkg::reg_t shift_res;
    openmips_pkg::reg_t move_res;
    openmips_pkg::reg_t hi_fwd;
    openmips_pkg::reg_t lo_fwd;
    logic [4:0]         shamt;

    assign shamt = op_i.reg1[4:0];

    // Logic unit
    always_comb begin
        case (op_i.aluop)
            openmips_pkg::EXE_OR_OP: begin
                logic_res = op_i.reg1 | op_i.reg2;
            end
            openmips_pkg::EXE_AND_OP: begin
                logic_res = op_i.reg1 & op_i.reg2;
            end
            openmips_pkg::EXE_XOR_OP: begin
                logic_res = op_i.reg1 ^ op_i.reg2;
            end
            openmips_pkg::EXE_NOR_OP: begin
                logic_res = ~(op_i.reg1 | op_i.reg2);
            end
            default: begin
                logic_res = openmips_pkg::ZERO_WORD;
            end
        endcase
    end

    // Shifter, amount from low five bits of reg1
    always_comb begin
        case (op_i.aluop)
            openmips_pkg::EXE_SLL_OP: begin
                shift_res = op_i.reg2 << shamt;
            end
            openmips_pkg::EXE_SRL_OP: begin
                shift_res = op_i.reg2 >> shamt;
            end
            openmips_pkg::EXE_SRA_OP: begin
                shift_res = openmips_pkg::reg_t'($signed(op_i.reg2) >>> shamt);
            end
            default: begin
                shift_res = openmips_pkg::ZERO_WORD;
            end
        endcase
    end

    // HI/LO hazard, youngest writer wins
    always_comb begin
        if (mem_hilo_i.whilo) begin
            hi_fwd = mem_hilo_i.hi;
            lo_fwd = mem_hilo_i.lo;
        end else if (wb_hilo_i.whilo) begin
            hi_fwd = wb_hilo_i.hi;
            lo_fwd = wb_hilo_i.lo;
        end else begin
            hi_fwd = hi_i;
            lo_fwd = lo_i;
        end
    end

    // Moves; MOVZ/MOVN condition is already folded into wreg
    always_comb begin
        case (op_i.aluop)
            openmips_pkg::EXE_MFHI_OP: begin
                move_res = hi_fwd;
            end
            openmips_pkg::EXE_MFLO_OP: begin
                move_res = lo_fwd;
            end
            openmips_pkg::EXE_MOVZ_OP,
            openmips_pkg::EXE_MOVN_OP: begin
                move_res = op_i.reg1;
            end
            default: begin
                move_res = openmips_pkg::ZERO_WORD;
            end
        endcase
    end

    // MTHI/MTLO keep the other half at its forwarded value
    always_comb begin
        if (op_i.aluop == openmips_pkg::EXE_MTHI_OP) begin
            hilo_o.whilo = 1'b1;
            hilo_o.hi    = op_i.reg1;
            hilo_o.lo    = lo_fwd;
        end else if (op_i.aluop == openmips_pkg::EXE_MTLO_OP) begin
            hilo_o.whilo = 1'b1;
            hilo_o.hi    = hi_fwd;
            hilo_o.lo    = op_i.reg1;
        end else begin
            hilo_o.whilo = 1'b0;
            hilo_o.hi    = openmips_pkg::ZERO_WORD;
            hilo_o.lo    = openmips_pkg::ZERO_WORD;
        end
    end

    // Write-back data by result class
    always_comb begin
        wb_o.wd   = op_i.wd;
        wb_o.wreg = op_i.wreg;
        case (op_i.alusel)
            openmips_pkg::EXE_RES_LOGIC: begin
                wb_o.wdata = logic_res;
            end
            openmips_pkg::EXE_RES_SHIFT: begin
                wb_o.wdata = shift_res;
            end
            openmips_pkg::EXE_RES_MOVE: begin
                wb_o.wdata = move_res;
            end
            openmips_pkg::EXE_RES_NOP: begin
                wb_o.wdata = openmips_pkg::ZERO_WORD;
            end
            default: begin
                wb_o.wdata = openmips_pkg::ZERO_WORD;
            end
        endcase
    end

    // Only MTHI/MTLO may reach the HI/LO write port
    always_comb begin
        assert (!hilo_o.whilo
                || op_i.aluop == openmips_pkg::EXE_MTHI_OP
                || op_i.aluop == openmips_pkg::EXE_MTLO_OP)
            else $error("ex: whilo set for aluop %h", op_i.aluop);
    end

endmodule

// File: openmips_pkg.sv
package openmips_pkg;

    localparam int REG_W      = 32;
    localparam int REG_ADDR_W = 5;
    localparam int ALUOP_W    = 8;
    localparam int ALUSEL_W   = 3;

    typedef logic [REG_W-1:0]      reg_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [ALUOP_W-1:0]    aluop_t;
    typedef logic [ALUSEL_W-1:0]   alusel_t;

    localparam reg_t ZERO_WORD = '0;

    // Operation codes
    localparam aluop_t EXE_AND_OP  = 8'b0010_0100;
    localparam aluop_t EXE_OR_OP   = 8'b0010_0101;
    localparam aluop_t EXE_XOR_OP  = 8'b0010_0110;
    localparam aluop_t EXE_NOR_OP  = 8'b0010_0111;
    localparam aluop_t EXE_SLL_OP  = 8'b0111_1100;
    localparam aluop_t EXE_SRL_OP  = 8'b0000_0010;
    localparam aluop_t EXE_SRA_OP  = 8'b0000_0011;
    localparam aluop_t EXE_MOVZ_OP = 8'b0000_1010;
    localparam aluop_t EXE_MOVN_OP = 8'b0000_1011;
    localparam aluop_t EXE_MFHI_OP = 8'b0001_0000;
    localparam aluop_t EXE_MTHI_OP = 8'b0001_0001;
    localparam aluop_t EXE_MFLO_OP = 8'b0001_0010;
    localparam aluop_t EXE_MTLO_OP = 8'b0001_0011;
    localparam aluop_t EXE_NOP_OP  = 8'b0000_0000;

    // Result class selectors
    localparam alusel_t EXE_RES_NOP   = 3'b000;
    localparam alusel_t EXE_RES_LOGIC = 3'b001;
    localparam alusel_t EXE_RES_SHIFT = 3'b010;
    localparam alusel_t EXE_RES_MOVE  = 3'b011;

    // Decoded instruction entering EX
    typedef struct packed {
        aluop_t    aluop;
        alusel_t   alusel;
        reg_t      reg1;
        reg_t      reg2;
        reg_addr_t wd;
        logic      wreg;
    } ex_op_t;

    // Register file write request
    typedef struct packed {
        reg_addr_t wd;
        logic      wreg;
        reg_t      wdata;
    } wb_req_t;

    // HI/LO write request
    typedef struct packed {
        reg_t hi;
        reg_t lo;
        logic whilo;
    } hilo_req_t;

endpackage
